/* design/alu_unit.sv */
module alu_unit (
  input  logic                            ram_clk,
  input  logic                            stage3_read,
  input  logic                            req,
  input  cpu_pkg::alu_cmd_t               cmd,
  output logic                            ack,
  output logic [cpu_pkg::REG_ADDR_W-1:0]  a_idx,
  input  logic [cpu_pkg::DATA_W-1:0]      a_data,
  output logic [cpu_pkg::REG_ADDR_W-1:0]  out_idx,
  input  logic [cpu_pkg::DATA_W-1:0]      out_data,
  output cpu_pkg::reg_wr_t                reg_wr
);

  typedef enum logic [1:0] {IDLE, RUN, DONE} alu_state_e;

  alu_state_e                  state;
  logic [cpu_pkg::DATA_W-1:0]  cnt;
  logic [cpu_pkg::DATA_W-1:0]  src_off;
  logic [cpu_pkg::DATA_W-1:0]  dst_off;
  logic [cpu_pkg::DATA_W-1:0]  result;

  assign src_off = cmd.src_start + cnt;
  assign dst_off = cmd.out_start + cnt;
  assign a_idx   = src_off[cpu_pkg::REG_ADDR_W-1:0];
  assign out_idx = dst_off[cpu_pkg::REG_ADDR_W-1:0];

  // no carry between bytes
  always_comb begin
    case (cmd.op)
      cpu_pkg::ALU_ADD:    result = out_data + a_data;
      cpu_pkg::ALU_ADDNUM: result = out_data + cmd.imm;
      default:             result = cmd.imm;
    endcase
  end

  assign reg_wr = '{en: (state == RUN), idx: out_idx, data: result};
  assign ack    = (state == DONE);

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            cnt   <= '0;
            state <= (cmd.len == '0) ? DONE : RUN;
          end
        end
        RUN: begin
          cnt   <= cnt + 8'd1;
          state <= (cnt + 8'd1 == cmd.len) ? DONE : RUN;
        end
        DONE: begin
          if (!req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* design/cpu_pkg.sv */
package cpu_pkg;

  localparam int DATA_W     = 8;
  localparam int ADDR_W     = 16;
  localparam int RAM_DEPTH  = 4096;
  localparam int RAM_AW     = $clog2(RAM_DEPTH);
  localparam int REG_COUNT  = 64;
  localparam int REG_ADDR_W = 6;

  localparam logic [ADDR_W-1:0] INSTR_BYTES = 16'd4;
  // program area starts above the one-byte data space
  localparam logic [ADDR_W-1:0] PROG_BASE   = 16'd256;

  typedef enum logic [7:0] {
    OP_HALT       = 8'd0,
    OP_LOAD       = 8'd1,
    OP_JUMP_MINUS = 8'd2,
    OP_STORE      = 8'd3,
    OP_ADD        = 8'd4,
    OP_JUMP_PLUS  = 8'd5,
    OP_ADDNUM     = 8'd6,
    OP_SET        = 8'd9
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_ADDNUM,
    ALU_SET
  } alu_op_e;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                  en;
    logic [REG_ADDR_W-1:0] idx;
    logic [DATA_W-1:0]     data;
  } reg_wr_t;

  // shared by load and store
  typedef struct packed {
    logic [DATA_W-1:0] reg_start;
    logic [DATA_W-1:0] len;
    logic [DATA_W-1:0] ram_addr;
  } xfer_cmd_t;

  typedef struct packed {
    alu_op_e           op;
    logic [DATA_W-1:0] imm;
    logic [DATA_W-1:0] src_start;
    logic [DATA_W-1:0] out_start;
    logic [DATA_W-1:0] len;
  } alu_cmd_t;

endpackage

/* design/cpu_top.sv */
module cpu_top (
  input  logic                        ram_clk,
  input  logic                        stage3_read,
  input  logic                        host_req,
  input  cpu_pkg::mem_req_t           host_cmd,
  output logic                        host_ack,
  output logic [cpu_pkg::DATA_W-1:0]  host_rdata,
  input  logic                        run_req,
  output logic                        run_ack
);

  logic                            fetch_req, fetch_ack;
  cpu_pkg::mem_req_t               fetch_cmd;
  logic                            ld_mem_req, ld_mem_ack;
  cpu_pkg::mem_req_t               ld_mem_cmd;
  logic                            st_mem_req, st_mem_ack;
  cpu_pkg::mem_req_t               st_mem_cmd;
  logic [cpu_pkg::DATA_W-1:0]      ram_rdata;
  logic                            load_req, load_ack;
  cpu_pkg::xfer_cmd_t              load_cmd;
  logic                            alu_req, alu_ack;
  cpu_pkg::alu_cmd_t               alu_cmd;
  logic                            store_req, store_ack;
  cpu_pkg::xfer_cmd_t              store_cmd;
  logic [cpu_pkg::REG_ADDR_W-1:0]  a_idx, s_idx, out_idx;
  logic [cpu_pkg::DATA_W-1:0]      a_data, s_data, out_data;
  cpu_pkg::reg_wr_t                load_wr, alu_wr;

  assign host_rdata = ram_rdata;

  mem_arbiter mem_arbiter_inst (
    .ram_clk, .stage3_read,
    .host_req, .host_cmd, .host_ack,
    .store_req(st_mem_req), .store_cmd(st_mem_cmd), .store_ack(st_mem_ack),
    .load_req(ld_mem_req), .load_cmd(ld_mem_cmd), .load_ack(ld_mem_ack),
    .fetch_req, .fetch_cmd, .fetch_ack,
    .rdata(ram_rdata)
  );

  reg_file reg_file_inst (
    .ram_clk, .stage3_read,
    .a_idx, .a_data, .s_idx, .s_data, .out_idx, .out_data,
    .load_wr, .alu_wr
  );

  instr_sequencer instr_sequencer_inst (
    .ram_clk, .stage3_read, .run_req, .run_ack,
    .fetch_req, .fetch_cmd, .fetch_ack, .rdata(ram_rdata),
    .load_req, .load_cmd, .load_ack,
    .alu_req, .alu_cmd, .alu_ack,
    .store_req, .store_cmd, .store_ack
  );

  load_unit load_unit_inst (
    .ram_clk, .stage3_read, .req(load_req), .cmd(load_cmd), .ack(load_ack),
    .mem_req(ld_mem_req), .mem_cmd(ld_mem_cmd), .mem_ack(ld_mem_ack),
    .rdata(ram_rdata), .reg_wr(load_wr)
  );

  alu_unit alu_unit_inst (
    .ram_clk, .stage3_read, .req(alu_req), .cmd(alu_cmd), .ack(alu_ack),
    .a_idx, .a_data, .out_idx, .out_data, .reg_wr(alu_wr)
  );

  store_unit store_unit_inst (
    .ram_clk, .stage3_read, .req(store_req), .cmd(store_cmd), .ack(store_ack),
    .s_idx, .s_data,
    .mem_req(st_mem_req), .mem_cmd(st_mem_cmd), .mem_ack(st_mem_ack)
  );

endmodule

/* design/instr_sequencer.sv */
module instr_sequencer (
  input  logic                        ram_clk,
  input  logic                        stage3_read,
  input  logic                        run_req,
  output logic                        run_ack,
  output logic                        fetch_req,
  output cpu_pkg::mem_req_t           fetch_cmd,
  input  logic                        fetch_ack,
  input  logic [cpu_pkg::DATA_W-1:0]  rdata,
  output logic                        load_req,
  output cpu_pkg::xfer_cmd_t          load_cmd,
  input  logic                        load_ack,
  output logic                        alu_req,
  output cpu_pkg::alu_cmd_t           alu_cmd,
  input  logic                        alu_ack,
  output logic                        store_req,
  output cpu_pkg::xfer_cmd_t          store_cmd,
  input  logic                        store_ack
);

  typedef enum logic [2:0] {
    S_IDLE, S_FETCH, S_GAP, S_DECODE, S_EXEC, S_EXEC_WAIT, S_HALT
  } seq_state_e;

  seq_state_e                  state;
  logic [cpu_pkg::ADDR_W-1:0]  pc;
  logic [1:0]                  bcnt;
  logic [cpu_pkg::DATA_W-1:0]  instr [4];
  cpu_pkg::opcode_e            op;
  logic                        is_alu;
  logic                        unit_ack;
  logic [cpu_pkg::ADDR_W-1:0]  jump_off;
  cpu_pkg::xfer_cmd_t          xfer;
  cpu_pkg::alu_op_e            alu_op;

  assign op       = cpu_pkg::opcode_e'(instr[0]);
  assign is_alu   = (op == cpu_pkg::OP_ADD) || (op == cpu_pkg::OP_ADDNUM) ||
                    (op == cpu_pkg::OP_SET);
  assign unit_ack = load_ack | alu_ack | store_ack;
  // jumps move in whole instructions
  assign jump_off = {{(cpu_pkg::ADDR_W-cpu_pkg::DATA_W){1'b0}}, instr[1]} *
                    cpu_pkg::INSTR_BYTES;

  assign fetch_req = (state == S_FETCH);
  assign fetch_cmd = '{we: 1'b0, addr: pc + {{(cpu_pkg::ADDR_W-2){1'b0}}, bcnt}, wdata: '0};

  assign xfer      = '{reg_start: instr[1], len: instr[2], ram_addr: instr[3]};
  assign load_cmd  = xfer;
  assign store_cmd = xfer;

  always_comb begin
    case (op)
      cpu_pkg::OP_ADD:    alu_op = cpu_pkg::ALU_ADD;
      cpu_pkg::OP_ADDNUM: alu_op = cpu_pkg::ALU_ADDNUM;
      default:            alu_op = cpu_pkg::ALU_SET;
    endcase
  end

  // b1 doubles as source start for add and as the immediate otherwise
  assign alu_cmd = '{op: alu_op, imm: instr[1], src_start: instr[1],
                     out_start: instr[2], len: instr[3]};

  assign load_req  = (state == S_EXEC) && (op == cpu_pkg::OP_LOAD);
  assign store_req = (state == S_EXEC) && (op == cpu_pkg::OP_STORE);
  assign alu_req   = (state == S_EXEC) && is_alu;
  assign run_ack   = (state == S_HALT);

  always_ff @(posedge ram_clk) begin
    if (state == S_FETCH && fetch_ack) begin
      instr[bcnt] <= rdata;
    end
  end

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      state <= S_IDLE;
      pc    <= cpu_pkg::PROG_BASE;
      bcnt  <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (run_req) begin
            bcnt  <= '0;
            state <= S_FETCH;
          end
        end
        S_FETCH: begin
          if (fetch_ack) begin
            state <= S_GAP;
          end
        end
        S_GAP: begin
          bcnt  <= bcnt + 2'd1;
          state <= (bcnt == 2'd3) ? S_DECODE : S_FETCH;
        end
        S_DECODE: begin
          case (op)
            cpu_pkg::OP_HALT: state <= S_HALT;
            cpu_pkg::OP_LOAD, cpu_pkg::OP_STORE, cpu_pkg::OP_ADD,
            cpu_pkg::OP_ADDNUM, cpu_pkg::OP_SET: state <= S_EXEC;
            cpu_pkg::OP_JUMP_PLUS: begin
              pc    <= pc + jump_off;
              state <= S_FETCH;
            end
            cpu_pkg::OP_JUMP_MINUS: begin
              pc    <= pc - jump_off;
              state <= S_FETCH;
            end
            default: begin
              pc    <= pc + cpu_pkg::INSTR_BYTES;
              state <= S_FETCH;
            end
          endcase
        end
        S_EXEC: begin
          if (unit_ack) begin
            pc    <= pc + cpu_pkg::INSTR_BYTES;
            state <= S_EXEC_WAIT;
          end
        end
        S_EXEC_WAIT: begin
          if (!unit_ack) begin
            state <= S_FETCH;
          end
        end
        S_HALT: begin
          if (!run_req) begin
            pc    <= cpu_pkg::PROG_BASE;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

/* design/load_unit.sv */
module load_unit (
  input  logic                        ram_clk,
  input  logic                        stage3_read,
  input  logic                        req,
  input  cpu_pkg::xfer_cmd_t          cmd,
  output logic                        ack,
  output logic                        mem_req,
  output cpu_pkg::mem_req_t           mem_cmd,
  input  logic                        mem_ack,
  input  logic [cpu_pkg::DATA_W-1:0]  rdata,
  output cpu_pkg::reg_wr_t            reg_wr
);

  typedef enum logic [1:0] {IDLE, READ, WRITE, DONE} load_state_e;

  load_state_e                 state;
  logic [cpu_pkg::DATA_W-1:0]  cnt;
  logic [cpu_pkg::DATA_W-1:0]  ram_off;
  logic [cpu_pkg::DATA_W-1:0]  reg_off;

  // data area wraps at 256
  assign ram_off = cmd.ram_addr + cnt;
  assign reg_off = cmd.reg_start + cnt;

  assign mem_req = (state == READ);
  assign mem_cmd = '{we: 1'b0,
                     addr: {{(cpu_pkg::ADDR_W-cpu_pkg::DATA_W){1'b0}}, ram_off},
                     wdata: '0};
  assign reg_wr  = '{en: (state == WRITE), idx: reg_off[cpu_pkg::REG_ADDR_W-1:0], data: rdata};
  assign ack     = (state == DONE);

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            cnt   <= '0;
            state <= (cmd.len == '0) ? DONE : READ;
          end
        end
        READ: begin
          if (mem_ack) begin
            state <= WRITE;
          end
        end
        WRITE: begin
          cnt   <= cnt + 8'd1;
          state <= (cnt + 8'd1 == cmd.len) ? DONE : READ;
        end
        DONE: begin
          if (!req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* design/mem_arbiter.sv */
module mem_arbiter (
  input  logic                        ram_clk,
  input  logic                        stage3_read,
  input  logic                        host_req,
  input  cpu_pkg::mem_req_t           host_cmd,
  output logic                        host_ack,
  input  logic                        store_req,
  input  cpu_pkg::mem_req_t           store_cmd,
  output logic                        store_ack,
  input  logic                        load_req,
  input  cpu_pkg::mem_req_t           load_cmd,
  output logic                        load_ack,
  input  logic                        fetch_req,
  input  cpu_pkg::mem_req_t           fetch_cmd,
  output logic                        fetch_ack,
  output logic [cpu_pkg::DATA_W-1:0]  rdata
);

  typedef enum logic [1:0] {IDLE, ACCESS, DONE} arb_state_e;

  arb_state_e        state;
  logic [3:0]        req_vec;
  logic [3:0]        pick;
  logic [3:0]        grant;
  cpu_pkg::mem_req_t cur;
  logic [cpu_pkg::DATA_W-1:0] ram [cpu_pkg::RAM_DEPTH];

  // bit 0 has the highest priority
  assign req_vec = {fetch_req, load_req, store_req, host_req};
  assign pick    = req_vec & (~req_vec + 4'd1);

  always_comb begin
    cur = fetch_cmd;
    if (grant[0]) begin
      cur = host_cmd;
    end else if (grant[1]) begin
      cur = store_cmd;
    end else if (grant[2]) begin
      cur = load_cmd;
    end
  end

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      state <= IDLE;
      grant <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (|req_vec) begin
            grant <= pick;
            state <= ACCESS;
          end
        end
        ACCESS: state <= DONE;
        DONE: begin
          // hold ack until the winner lets go
          if (!(|(req_vec & grant))) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge ram_clk) begin
    if (state == ACCESS) begin
      if (cur.we) begin
        ram[cur.addr[cpu_pkg::RAM_AW-1:0]] <= cur.wdata;
      end else begin
        rdata <= ram[cur.addr[cpu_pkg::RAM_AW-1:0]];
      end
    end
  end

  assign {fetch_ack, load_ack, store_ack, host_ack} = {4{state == DONE}} & grant;

endmodule

/* design/reg_file.sv */
module reg_file (
  input  logic                            ram_clk,
  input  logic                            stage3_read,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  a_idx,
  output logic [cpu_pkg::DATA_W-1:0]      a_data,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  s_idx,
  output logic [cpu_pkg::DATA_W-1:0]      s_data,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  out_idx,
  output logic [cpu_pkg::DATA_W-1:0]      out_data,
  input  cpu_pkg::reg_wr_t                load_wr,
  input  cpu_pkg::reg_wr_t                alu_wr
);

  logic [cpu_pkg::DATA_W-1:0] regs [cpu_pkg::REG_COUNT];

  assign a_data   = regs[a_idx];
  assign s_data   = regs[s_idx];
  assign out_data = regs[out_idx];

  // load and alu never write in the same cycle
  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (load_wr.en) begin
      regs[load_wr.idx] <= load_wr.data;
    end else if (alu_wr.en) begin
      regs[alu_wr.idx] <= alu_wr.data;
    end
  end

endmodule

/* design/store_unit.sv */
module store_unit (
  input  logic                            ram_clk,
  input  logic                            stage3_read,
  input  logic                            req,
  input  cpu_pkg::xfer_cmd_t              cmd,
  output logic                            ack,
  output logic [cpu_pkg::REG_ADDR_W-1:0]  s_idx,
  input  logic [cpu_pkg::DATA_W-1:0]      s_data,
  output logic                            mem_req,
  output cpu_pkg::mem_req_t               mem_cmd,
  input  logic                            mem_ack
);

  typedef enum logic [1:0] {IDLE, WRITE, NEXT, DONE} store_state_e;

  store_state_e                state;
  logic [cpu_pkg::DATA_W-1:0]  cnt;
  logic [cpu_pkg::DATA_W-1:0]  ram_off;
  logic [cpu_pkg::DATA_W-1:0]  reg_off;

  assign ram_off = cmd.ram_addr + cnt;
  assign reg_off = cmd.reg_start + cnt;
  assign s_idx   = reg_off[cpu_pkg::REG_ADDR_W-1:0];

  assign mem_req = (state == WRITE);
  assign mem_cmd = '{we: 1'b1,
                     addr: {{(cpu_pkg::ADDR_W-cpu_pkg::DATA_W){1'b0}}, ram_off},
                     wdata: s_data};
  assign ack     = (state == DONE);

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            cnt   <= '0;
            state <= (cmd.len == '0) ? DONE : WRITE;
          end
        end
        WRITE: begin
          if (mem_ack) begin
            state <= NEXT;
          end
        end
        // req is low here so the arbiter can release ack
        NEXT: begin
          cnt   <= cnt + 8'd1;
          state <= (cnt + 8'd1 == cmd.len) ? DONE : WRITE;
        end
        DONE: begin
          if (!req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module cpu_tb -f verilog.f -o cpu_sim
./obj_dir/cpu_sim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  echo "result: pass"
else
  echo "result: fail"
  exit 1
fi

/* sim/cpu_tb.sv */
module cpu_tb;

  logic              ram_clk;
  logic              stage3_read;
  logic              host_req;
  cpu_pkg::mem_req_t host_cmd;
  logic              host_ack;
  logic [7:0]        host_rdata;
  logic              run_req;
  logic              run_ack;

  // model state persists across runs, like the DUT
  logic [7:0]  model_mem [cpu_pkg::RAM_DEPTH];
  logic [7:0]  model_regs [cpu_pkg::REG_COUNT];
  logic [7:0]  dut_bytes [256];
  logic [15:0] lfsr;
  int          data_errors = 0;
  int          ctrl_errors = 0;
  int          instr_total = 0;
  int          host_ops = 0;
  int          cycles = 0;
  int          cmp_req_cnt = 0;
  int          cmp_done_cnt = 0;

  cpu_top cpu_top_inst (
    .ram_clk, .stage3_read,
    .host_req, .host_cmd, .host_ack, .host_rdata,
    .run_req, .run_ack
  );

  initial begin
    ram_clk = 1'b0;
    forever #5 ram_clk = ~ram_clk;
  end

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic int run_model();
    logic [15:0] pc;
    logic [15:0] off;
    logic [7:0]  b0, b1, b2, b3, r8, m8, s8;
    int          steps;
    logic        done;
    pc = cpu_pkg::PROG_BASE;
    steps = 0;
    done = 1'b0;
    while (!done && steps < 1000) begin
      b0 = model_mem[pc[11:0]];
      b1 = model_mem[pc[11:0] + 12'd1];
      b2 = model_mem[pc[11:0] + 12'd2];
      b3 = model_mem[pc[11:0] + 12'd3];
      off = {6'd0, b1, 2'b00};
      steps++;
      case (b0)
        cpu_pkg::OP_HALT: done = 1'b1;
        cpu_pkg::OP_LOAD: begin
          for (int i = 0; i < int'(b2); i++) begin
            r8 = b1 + 8'(i);
            m8 = b3 + 8'(i);
            model_regs[r8[5:0]] = model_mem[{4'd0, m8}];
          end
        end
        cpu_pkg::OP_STORE: begin
          for (int i = 0; i < int'(b2); i++) begin
            r8 = b1 + 8'(i);
            m8 = b3 + 8'(i);
            model_mem[{4'd0, m8}] = model_regs[r8[5:0]];
          end
        end
        cpu_pkg::OP_ADD, cpu_pkg::OP_ADDNUM, cpu_pkg::OP_SET: begin
          for (int i = 0; i < int'(b3); i++) begin
            r8 = b2 + 8'(i);
            s8 = b1 + 8'(i);
            if (b0 == cpu_pkg::OP_ADD) begin
              model_regs[r8[5:0]] = model_regs[r8[5:0]] + model_regs[s8[5:0]];
            end else if (b0 == cpu_pkg::OP_ADDNUM) begin
              model_regs[r8[5:0]] = model_regs[r8[5:0]] + b1;
            end else begin
              model_regs[r8[5:0]] = b1;
            end
          end
        end
        default: ;
      endcase
      if (b0 == cpu_pkg::OP_JUMP_PLUS) begin
        pc = pc + off;
      end else if (b0 == cpu_pkg::OP_JUMP_MINUS) begin
        pc = pc - off;
      end else if (!done) begin
        pc = pc + 16'd4;
      end
    end
    return steps;
  endfunction

  task automatic write_mem(input logic [15:0] addr, input logic [7:0] data);
    @(negedge ram_clk);
    host_cmd = '{we: 1'b1, addr: addr, wdata: data};
    host_req = 1'b1;
    while (!host_ack) @(negedge ram_clk);
    host_req = 1'b0;
    while (host_ack) @(negedge ram_clk);
    model_mem[addr[11:0]] = data;
    host_ops++;
  endtask

  task automatic read_mem(input logic [15:0] addr, output logic [7:0] data);
    @(negedge ram_clk);
    host_cmd = '{we: 1'b0, addr: addr, wdata: 8'd0};
    host_req = 1'b1;
    while (!host_ack) @(negedge ram_clk);
    data = host_rdata;
    host_req = 1'b0;
    while (host_ack) @(negedge ram_clk);
    host_ops++;
  endtask

  task automatic put_instr(input int idx, input logic [7:0] op, input logic [7:0] b1,
                           input logic [7:0] b2, input logic [7:0] b3);
    logic [15:0] base;
    base = cpu_pkg::PROG_BASE + 16'(4 * idx);
    write_mem(base, op);
    write_mem(base + 16'd1, b1);
    write_mem(base + 16'd2, b2);
    write_mem(base + 16'd3, b3);
  endtask

  task automatic run_program();
    int n;
    n = run_model();
    instr_total += n;
    @(negedge ram_clk);
    run_req = 1'b1;
    while (!run_ack) @(negedge ram_clk);
    @(negedge ram_clk);
    if (!run_ack) begin
      $display("[ERROR] %0t: run_ack fell while run_req was high", $time);
      ctrl_errors++;
    end
    run_req = 1'b0;
    while (run_ack) @(negedge ram_clk);
    for (int a = 0; a < 256; a++) begin
      read_mem(16'(a), dut_bytes[a[7:0]]);
    end
    cmp_req_cnt++;
    wait (cmp_done_cnt == cmp_req_cnt);
  endtask

  // compares the data area after each run
  initial begin
    forever begin
      wait (cmp_req_cnt != cmp_done_cnt);
      for (int a = 0; a < 256; a++) begin
        if (dut_bytes[a[7:0]] !== model_mem[{4'd0, a[7:0]}]) begin
          $display("[ERROR] %0t: addr %0d expected %02h got %02h", $time, a,
                   model_mem[{4'd0, a[7:0]}], dut_bytes[a[7:0]]);
          data_errors++;
        end
      end
      cmp_done_cnt++;
    end
  end

  // budget grows with the work queued so far
  initial begin
    while (cycles <= 200 * instr_total + 10 * host_ops + 1000) begin
      @(posedge ram_clk);
      cycles++;
    end
    $display("timeout: the DUT did not finish within %0d cycles", cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    logic [7:0]  rd, sel, opc, b1, x, len;
    logic [15:0] addr16;
    stage3_read = 1'b1;
    host_req = 1'b0;
    host_cmd = '0;
    run_req = 1'b0;
    lfsr = 16'd26;
    for (int a = 0; a < cpu_pkg::RAM_DEPTH; a++) begin
      model_mem[a[11:0]] = '0;
    end
    for (int r = 0; r < cpu_pkg::REG_COUNT; r++) begin
      model_regs[r[5:0]] = '0;
    end
    repeat (5) @(negedge ram_clk);
    stage3_read = 1'b0;

    if (host_ack !== 1'b0 || run_ack !== 1'b0) begin
      $display("[ERROR] %0t: ack high after reset", $time);
      ctrl_errors++;
    end
    for (int i = 0; i < 4; i++) begin
      write_mem(16'h0400 + 16'(i), rand_bits(8));
    end
    for (int i = 0; i < 4; i++) begin
      addr16 = 16'h0400 + 16'(i);
      read_mem(addr16, rd);
      if (rd !== model_mem[addr16[11:0]]) begin
        $display("[ERROR] %0t: host readback addr %0d expected %02h got %02h", $time,
                 addr16, model_mem[addr16[11:0]], rd);
        ctrl_errors++;
      end
    end
    for (int a = 0; a < 256; a++) begin
      write_mem(16'(a), rand_bits(8));
    end

    // block copy around an empty load, then an empty store
    put_instr(0, cpu_pkg::OP_LOAD, 8'd20, 8'd16, 8'd48);
    put_instr(1, cpu_pkg::OP_LOAD, 8'd20, 8'd0, 8'd0);
    put_instr(2, cpu_pkg::OP_STORE, 8'd20, 8'd16, 8'd96);
    put_instr(3, cpu_pkg::OP_STORE, 8'd0, 8'd0, 8'd96);
    put_instr(4, cpu_pkg::OP_HALT, 8'd0, 8'd0, 8'd0);
    run_program();

    // alu ops wrapping past 255 and past r63, plus unused opcodes
    put_instr(0, cpu_pkg::OP_SET, 8'd250, 8'd60, 8'd8);
    put_instr(1, cpu_pkg::OP_ADDNUM, 8'd10, 8'd60, 8'd8);
    put_instr(2, cpu_pkg::OP_LOAD, 8'd10, 8'd6, 8'd32);
    put_instr(3, cpu_pkg::OP_ADD, 8'd10, 8'd125, 8'd6);
    put_instr(4, 8'h07, 8'd1, 8'd2, 8'd3);
    put_instr(5, 8'hff, 8'd4, 8'd5, 8'd6);
    put_instr(6, cpu_pkg::OP_STORE, 8'd60, 8'd12, 8'd140);
    put_instr(7, cpu_pkg::OP_HALT, 8'd0, 8'd0, 8'd0);
    run_program();

    // forward jump over 1 and 2, backward loop taken once
    put_instr(0, cpu_pkg::OP_JUMP_PLUS, 8'd3, 8'd0, 8'd0);
    put_instr(1, cpu_pkg::OP_STORE, 8'd0, 8'd4, 8'd200);
    put_instr(2, cpu_pkg::OP_HALT, 8'd0, 8'd0, 8'd0);
    put_instr(3, cpu_pkg::OP_ADDNUM, 8'd5, 8'd0, 8'd4);
    put_instr(4, cpu_pkg::OP_JUMP_MINUS, 8'd3, 8'd0, 8'd0);
    run_program();

    for (int p = 0; p < 10; p++) begin
      for (int a = 0; a < 32; a++) begin
        write_mem(16'(a), rand_bits(8));
      end
      for (int k = 0; k < 8; k++) begin
        sel = rand_bits(3);
        b1 = rand_bits(8);
        x = rand_bits(8);
        len = rand_bits(4);
        case (sel)
          8'd0, 8'd5: opc = cpu_pkg::OP_LOAD;
          8'd1, 8'd6: opc = cpu_pkg::OP_STORE;
          8'd2: opc = cpu_pkg::OP_ADD;
          8'd3: opc = cpu_pkg::OP_ADDNUM;
          8'd4: opc = cpu_pkg::OP_SET;
          default: opc = 8'h07;
        endcase
        if (opc == cpu_pkg::OP_LOAD || opc == cpu_pkg::OP_STORE) begin
          put_instr(k, opc, b1, len, x);
        end else begin
          put_instr(k, opc, b1, x, len);
        end
      end
      put_instr(8, cpu_pkg::OP_HALT, 8'd0, 8'd0, 8'd0);
      run_program();
    end

    $display("errors: %0d data, %0d control", data_errors, ctrl_errors);
    if (data_errors + ctrl_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
design/cpu_pkg.sv
design/mem_arbiter.sv
design/reg_file.sv
design/instr_sequencer.sv
design/load_unit.sv
design/alu_unit.sv
design/store_unit.sv
design/cpu_top.sv
sim/cpu_tb.sv
